// File: hdl/i2s_pkg.sv
`default_nettype none

package i2s_pkg;

    // Register map
    localparam int REG_ADDR_CNTRL = 0;
    localparam int REG_ADDR_DATAL = 1;
    localparam int REG_ADDR_DATAR = 2;

    localparam int BUS_W    = 32;
    localparam int SAMPLE_W = 24;
    localparam int FRAME_W  = 2 * SAMPLE_W;

    // 16-entry sample FIFO
    localparam int FIFO_AW    = 4;
    localparam int FIFO_DEPTH = 1 << FIFO_AW;

    // SCLK periods per channel slot
    localparam int SLOT_BITS = 32;
    // Audio clocks per SCLK half period
    localparam int SCLK_HALF = 4;

    typedef logic [SAMPLE_W-1:0] sample_t;

    // Left in bits 23..0, right in bits 47..24
    typedef logic [FRAME_W-1:0] frame_t;

    typedef logic [BUS_W-1:0] bus_word_t;

    // One extra bit to tell full from empty
    typedef logic [FIFO_AW:0] fifo_ptr_t;

    typedef enum logic {
        SER_IDLE,
        SER_RUN
    } ser_state_t;

endpackage

`default_nettype wire

// File: hdl/i2s_bus_regs.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_bus_regs
    import i2s_pkg::*;
#(
    parameter int ADDR_SEL_BITS = 0
) (
    input  wire                      i_Clk,
    input  wire                      i_rst_n,
    input  wire                      i_SlaveSel,
    input  wire [29-ADDR_SEL_BITS:0] i_RegAddr,
    input  wire [3:0]                i_AV_ByteEn,
    input  wire                      i_AV_Read,
    input  wire                      i_AV_Write,
    input  wire bus_word_t           i_AV_WriteData,
    input  wire                      i_fifo_full,
    input  wire                      i_fifo_almost_full,
    output bus_word_t                o_AV_ReadData,
    output frame_t                   o_fifo_din,
    output logic                     o_fifo_wr_en
);

    logic [1:0] r_rst_sync;
    logic       w_rst_n;
    frame_t     r_stage;
    logic       w_wr_valid;
    logic       w_rd_valid;
    logic       w_status;

    // Local reset synchronizer for the bus domain
    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            r_rst_sync <= 2'b00;
        end else begin
            r_rst_sync <= {r_rst_sync[0], 1'b1};
        end
    end

    assign w_rst_n = r_rst_sync[1];

    assign w_wr_valid = i_SlaveSel && i_AV_Write;
    assign w_rd_valid = i_SlaveSel && i_AV_Read;

    // A push in flight may take the last free entry
    assign w_status = o_fifo_wr_en ? (i_fifo_full || i_fifo_almost_full) : i_fifo_full;

    assign o_fifo_din = r_stage;

    always_ff @(posedge i_Clk) begin
        if (!w_rst_n) begin
            r_stage       <= '0;
            o_fifo_wr_en  <= 1'b0;
            o_AV_ReadData <= '0;
        end else begin
            o_fifo_wr_en  <= 1'b0;
            o_AV_ReadData <= '0;

            if (w_wr_valid) begin
                case (i_RegAddr)
                    REG_ADDR_CNTRL: begin
                        // Read-only for now
                    end
                    REG_ADDR_DATAL: begin
                        for (int b = 0; b < 3; b++) begin
                            if (i_AV_ByteEn[b]) begin
                                r_stage[8*b +: 8] <= i_AV_WriteData[8*b +: 8];
                            end
                        end
                    end
                    REG_ADDR_DATAR: begin
                        for (int b = 0; b < 3; b++) begin
                            if (i_AV_ByteEn[b]) begin
                                r_stage[SAMPLE_W + 8*b +: 8] <= i_AV_WriteData[8*b +: 8];
                            end
                        end
                        // Top byte of right sample completes the frame
                        if (i_AV_ByteEn[2]) begin
                            o_fifo_wr_en <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end

            if (w_rd_valid) begin
                case (i_RegAddr)
                    REG_ADDR_CNTRL: o_AV_ReadData <= bus_word_t'(w_status);
                    REG_ADDR_DATAL: o_AV_ReadData <= bus_word_t'(r_stage[SAMPLE_W-1:0]);
                    REG_ADDR_DATAR: o_AV_ReadData <= bus_word_t'(r_stage[FRAME_W-1:SAMPLE_W]);
                    default:        o_AV_ReadData <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2s_sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_sample_fifo
    import i2s_pkg::*;
(
    input  wire         i_Clk,
    input  wire         i_Audio_Clk,
    input  wire         i_rst_n,
    input  wire frame_t i_din,
    input  wire         i_wr_en,
    input  wire         i_rd_en,
    output frame_t      o_dout,
    output logic        o_full,
    output logic        o_almost_full,
    output logic        o_empty
);

    frame_t     r_mem [FIFO_DEPTH];

    logic [1:0] r_wr_rst_sync;
    logic [1:0] r_rd_rst_sync;
    logic       w_wr_rst_n;
    logic       w_rd_rst_n;

    fifo_ptr_t  r_wr_bin;
    fifo_ptr_t  r_wr_gray;
    fifo_ptr_t  r_rd_bin;
    fifo_ptr_t  r_rd_gray;
    fifo_ptr_t  r_rq1_gray;
    fifo_ptr_t  r_rq2_gray;
    fifo_ptr_t  r_wq1_gray;
    fifo_ptr_t  r_wq2_gray;

    fifo_ptr_t  w_wr_bin_next;
    fifo_ptr_t  w_rd_bin_next;
    fifo_ptr_t  w_rq2_bin;
    fifo_ptr_t  w_wr_count;
    logic       w_wr_accept;
    logic       w_rd_accept;

    function automatic fifo_ptr_t bin2gray(input fifo_ptr_t b);
        return b ^ (b >> 1);
    endfunction

    function automatic fifo_ptr_t gray2bin(input fifo_ptr_t g);
        fifo_ptr_t b;
        b[FIFO_AW] = g[FIFO_AW];
        for (int i = FIFO_AW - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // Write side, bus clock
    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            r_wr_rst_sync <= 2'b00;
        end else begin
            r_wr_rst_sync <= {r_wr_rst_sync[0], 1'b1};
        end
    end

    assign w_wr_rst_n = r_wr_rst_sync[1];

    assign w_rq2_bin     = gray2bin(r_rq2_gray);
    assign w_wr_count    = r_wr_bin - w_rq2_bin;
    assign o_full        = (w_wr_count == fifo_ptr_t'(FIFO_DEPTH));
    assign o_almost_full = (w_wr_count >= fifo_ptr_t'(FIFO_DEPTH - 1));
    assign w_wr_accept   = i_wr_en && !o_full;
    assign w_wr_bin_next = r_wr_bin + 1'b1;

    always_ff @(posedge i_Clk) begin
        if (!w_wr_rst_n) begin
            r_wr_bin   <= '0;
            r_wr_gray  <= '0;
            r_rq1_gray <= '0;
            r_rq2_gray <= '0;
        end else begin
            r_rq1_gray <= r_rd_gray;
            r_rq2_gray <= r_rq1_gray;
            if (w_wr_accept) begin
                r_wr_bin  <= w_wr_bin_next;
                r_wr_gray <= bin2gray(w_wr_bin_next);
            end
        end
    end

    always_ff @(posedge i_Clk) begin
        if (w_wr_accept) begin
            r_mem[r_wr_bin[FIFO_AW-1:0]] <= i_din;
        end
    end

    // Read side, audio clock
    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            r_rd_rst_sync <= 2'b00;
        end else begin
            r_rd_rst_sync <= {r_rd_rst_sync[0], 1'b1};
        end
    end

    assign w_rd_rst_n = r_rd_rst_sync[1];

    assign o_empty       = (r_rd_gray == r_wq2_gray);
    assign w_rd_accept   = i_rd_en && !o_empty;
    assign w_rd_bin_next = r_rd_bin + 1'b1;

    // Head entry is visible before the pop
    assign o_dout = r_mem[r_rd_bin[FIFO_AW-1:0]];

    always_ff @(posedge i_Audio_Clk) begin
        if (!w_rd_rst_n) begin
            r_rd_bin   <= '0;
            r_rd_gray  <= '0;
            r_wq1_gray <= '0;
            r_wq2_gray <= '0;
        end else begin
            r_wq1_gray <= r_wr_gray;
            r_wq2_gray <= r_wq1_gray;
            if (w_rd_accept) begin
                r_rd_bin  <= w_rd_bin_next;
                r_rd_gray <= bin2gray(w_rd_bin_next);
            end
        end
    end

    a_no_overflow: assert property (
        @(posedge i_Clk) disable iff (!w_wr_rst_n)
        w_wr_count <= fifo_ptr_t'(FIFO_DEPTH)
    ) else $error("FIFO occupancy beyond depth");

    a_no_read_empty: assert property (
        @(posedge i_Audio_Clk) disable iff (!w_rd_rst_n)
        i_rd_en |-> !o_empty
    ) else $error("FIFO popped while empty");

endmodule

`default_nettype wire

// File: hdl/i2s_frame_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_frame_feeder
    import i2s_pkg::*;
(
    input  wire         i_Audio_Clk,
    input  wire         i_rst_n,
    input  wire         i_req_next,
    input  wire frame_t i_fifo_dout,
    input  wire         i_fifo_empty,
    output logic        o_fifo_rd_en,
    output frame_t      o_frame
);

    logic [1:0] r_rst_sync;
    logic       w_rst_n;
    logic       r_req_prev;
    logic       w_req_rise;

    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            r_rst_sync <= 2'b00;
        end else begin
            r_rst_sync <= {r_rst_sync[0], 1'b1};
        end
    end

    assign w_rst_n    = r_rst_sync[1];
    assign w_req_rise = i_req_next && !r_req_prev;

    always_ff @(posedge i_Audio_Clk) begin
        if (!w_rst_n) begin
            r_req_prev   <= 1'b0;
            o_fifo_rd_en <= 1'b0;
            o_frame      <= '0;
        end else begin
            r_req_prev   <= i_req_next;
            o_fifo_rd_en <= 1'b0;
            if (w_req_rise) begin
                if (i_fifo_empty) begin
                    // Underrun plays silence
                    o_frame <= '0;
                end else begin
                    o_frame      <= i_fifo_dout;
                    o_fifo_rd_en <= 1'b1;
                end
            end
        end
    end

    a_single_pop: assert property (
        @(posedge i_Audio_Clk) disable iff (!w_rst_n)
        o_fifo_rd_en |=> !o_fifo_rd_en
    ) else $error("back-to-back FIFO pops");

endmodule

`default_nettype wire

// File: hdl/i2s_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_serializer
    import i2s_pkg::*;
(
    input  wire         i_Audio_Clk,
    input  wire         i_rst_n,
    input  wire frame_t i_frame,
    output logic        o_req_next,
    output logic        o_SDIN,
    output logic        o_SCLK,
    output logic        o_LRCK,
    output logic        o_MCLK
);

    ser_state_t                       r_state;
    logic [1:0]                       r_rst_sync;
    logic                             w_rst_n;
    logic [$clog2(2*SCLK_HALF)-1:0]   r_div;
    logic [$clog2(2*SLOT_BITS)-1:0]   r_bit;
    logic [$clog2(2*SLOT_BITS)-1:0]   w_bit_next;
    logic [2*SLOT_BITS-1:0]           r_shift;
    logic [2*SLOT_BITS-1:0]           w_frame_slots;
    sample_t                          w_left;
    sample_t                          w_right;
    logic                             w_sclk_fall;

    always_ff @(posedge i_Audio_Clk) begin
        if (!i_rst_n) begin
            r_rst_sync <= 2'b00;
        end else begin
            r_rst_sync <= {r_rst_sync[0], 1'b1};
        end
    end

    assign w_rst_n = r_rst_sync[1];

    assign w_left  = i_frame[SAMPLE_W-1:0];
    assign w_right = i_frame[FRAME_W-1:SAMPLE_W];

    // Each slot is 24 data bits then zero padding
    assign w_frame_slots = {w_left, {(SLOT_BITS - SAMPLE_W){1'b0}},
                            w_right, {(SLOT_BITS - SAMPLE_W){1'b0}}};

    assign w_sclk_fall = (r_div == 2 * SCLK_HALF - 1);
    assign w_bit_next  = r_bit + 1'b1;

    // Request the next frame for the whole right slot
    assign o_req_next = o_LRCK;

    always_ff @(posedge i_Audio_Clk) begin
        if (!w_rst_n) begin
            r_state <= SER_IDLE;
            r_div   <= '0;
            r_bit   <= '0;
            r_shift <= '0;
            o_SDIN  <= 1'b0;
            o_SCLK  <= 1'b0;
            o_LRCK  <= 1'b0;
            o_MCLK  <= 1'b0;
        end else begin
            case (r_state)
                SER_IDLE: begin
                    r_state <= SER_RUN;
                    r_shift <= w_frame_slots;
                end
                SER_RUN: begin
                    o_MCLK <= ~o_MCLK;
                    if (w_sclk_fall) begin
                        r_div <= '0;
                    end else begin
                        r_div <= r_div + 1'b1;
                    end

                    if (r_div == SCLK_HALF - 1) begin
                        o_SCLK <= 1'b1;
                    end

                    // Data and LRCK move on SCLK falling edges
                    if (w_sclk_fall) begin
                        o_SCLK <= 1'b0;
                        r_bit  <= w_bit_next;
                        o_LRCK <= (w_bit_next >= SLOT_BITS);
                        if (w_bit_next == '0) begin
                            // Frame start, one-bit offset before MSB
                            r_shift <= w_frame_slots;
                            o_SDIN  <= 1'b0;
                        end else begin
                            o_SDIN  <= r_shift[2*SLOT_BITS-1];
                            r_shift <= r_shift << 1;
                        end
                    end
                end
                default: begin
                    r_state <= SER_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/i2s_bus_interface.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_bus_interface
    import i2s_pkg::*;
#(
    parameter int ADDR_SEL_BITS = 0
) (
    input  wire                      i_Clk,
    input  wire                      i_Audio_Clk,
    input  wire                      i_rst_n,
    input  wire                      i_SlaveSel,
    input  wire [29-ADDR_SEL_BITS:0] i_RegAddr,
    input  wire [3:0]                i_AV_ByteEn,
    input  wire                      i_AV_Read,
    input  wire                      i_AV_Write,
    input  wire bus_word_t           i_AV_WriteData,
    output wire bus_word_t           o_AV_ReadData,
    output wire                      o_I2S0_SDIN,
    output wire                      o_I2S0_SCLK,
    output wire                      o_I2S0_LRCK,
    output wire                      o_I2S0_MCLK
);

    frame_t w_fifo_din;
    logic   w_fifo_wr_en;
    logic   w_fifo_full;
    logic   w_fifo_almost_full;
    frame_t w_fifo_dout;
    logic   w_fifo_rd_en;
    logic   w_fifo_empty;
    logic   w_req_next;
    frame_t w_frame;

    i2s_bus_regs #(
        .ADDR_SEL_BITS(ADDR_SEL_BITS)
    ) u_bus_regs (
        .i_Clk             (i_Clk),
        .i_rst_n           (i_rst_n),
        .i_SlaveSel        (i_SlaveSel),
        .i_RegAddr         (i_RegAddr),
        .i_AV_ByteEn       (i_AV_ByteEn),
        .i_AV_Read         (i_AV_Read),
        .i_AV_Write        (i_AV_Write),
        .i_AV_WriteData    (i_AV_WriteData),
        .i_fifo_full       (w_fifo_full),
        .i_fifo_almost_full(w_fifo_almost_full),
        .o_AV_ReadData     (o_AV_ReadData),
        .o_fifo_din        (w_fifo_din),
        .o_fifo_wr_en      (w_fifo_wr_en)
    );

    i2s_sample_fifo u_sample_fifo (
        .i_Clk        (i_Clk),
        .i_Audio_Clk  (i_Audio_Clk),
        .i_rst_n      (i_rst_n),
        .i_din        (w_fifo_din),
        .i_wr_en      (w_fifo_wr_en),
        .i_rd_en      (w_fifo_rd_en),
        .o_dout       (w_fifo_dout),
        .o_full       (w_fifo_full),
        .o_almost_full(w_fifo_almost_full),
        .o_empty      (w_fifo_empty)
    );

    i2s_frame_feeder u_frame_feeder (
        .i_Audio_Clk (i_Audio_Clk),
        .i_rst_n     (i_rst_n),
        .i_req_next  (w_req_next),
        .i_fifo_dout (w_fifo_dout),
        .i_fifo_empty(w_fifo_empty),
        .o_fifo_rd_en(w_fifo_rd_en),
        .o_frame     (w_frame)
    );

    i2s_serializer u_serializer (
        .i_Audio_Clk(i_Audio_Clk),
        .i_rst_n    (i_rst_n),
        .i_frame    (w_frame),
        .o_req_next (w_req_next),
        .o_SDIN     (o_I2S0_SDIN),
        .o_SCLK     (o_I2S0_SCLK),
        .o_LRCK     (o_I2S0_LRCK),
        .o_MCLK     (o_I2S0_MCLK)
    );

endmodule

`default_nettype wire

// File: sim/tb_i2s_bus_interface.sv
`timescale 1ns/1ps
`default_nettype none

module tb_i2s_bus_interface
    import i2s_pkg::*;
();

    // One stereo frame is 64 SCLK periods of 8 audio clocks
    localparam int FRAME_CLKS  = 2 * SLOT_BITS * 2 * SCLK_HALF;
    localparam int FRAME_NS    = FRAME_CLKS * 10;
    localparam int TEST_FRAMES = 60;
    localparam int WATCHDOG_NS = TEST_FRAMES * FRAME_NS + 20000;

    logic        i_Clk = 1'b0;
    logic        i_Audio_Clk = 1'b0;
    logic        i_rst_n;
    logic        i_SlaveSel;
    logic [29:0] i_RegAddr;
    logic [3:0]  i_AV_ByteEn;
    logic        i_AV_Read;
    logic        i_AV_Write;
    bus_word_t   i_AV_WriteData;
    bus_word_t   o_AV_ReadData;
    logic        o_I2S0_SDIN;
    logic        o_I2S0_SCLK;
    logic        o_I2S0_LRCK;
    logic        o_I2S0_MCLK;

    frame_t      rx_q[$];
    frame_t      sent_q[$];
    sample_t     rx_left;
    sample_t     rx_right;
    logic        rx_prev_lrck = 1'b0;
    logic        rx_synced = 1'b0;
    int          rx_bit = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_start = 0;

    always #5 i_Audio_Clk = ~i_Audio_Clk;
    always #3 i_Clk = ~i_Clk;

    i2s_bus_interface #(
        .ADDR_SEL_BITS(0)
    ) UUT (.*);

    // Receiver pushes a frame at each LRCK falling edge
    always @(posedge o_I2S0_SCLK) begin
        if (o_I2S0_LRCK != rx_prev_lrck) begin
            if (!o_I2S0_LRCK && rx_synced) begin
                rx_q.push_back({rx_right, rx_left});
            end
            if (!o_I2S0_LRCK) begin
                rx_synced = 1'b1;
            end
            // Offset bit after the LRCK change
            rx_bit = 0;
        end else if (rx_bit < SAMPLE_W) begin
            rx_bit++;
            if (o_I2S0_LRCK) begin
                rx_right = {rx_right[SAMPLE_W-2:0], o_I2S0_SDIN};
            end else begin
                rx_left = {rx_left[SAMPLE_W-2:0], o_I2S0_SDIN};
            end
        end
        rx_prev_lrck = o_I2S0_LRCK;
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_frame(input string name, input frame_t got, input frame_t exp);
        checks++;
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    // MCLK is the audio clock divided by 2
    task automatic check_mclk();
        logic level;
        @(negedge i_Audio_Clk);
        level = o_I2S0_MCLK;
        check_bit("o_I2S0_MCLK unknown", $isunknown(level), 1'b0);
        repeat (8) begin
            @(negedge i_Audio_Clk);
            level = ~level;
            check_bit("o_I2S0_MCLK", o_I2S0_MCLK, level);
        end
    endtask

    task automatic bus_write(input int addr, input logic [3:0] byteen, input bus_word_t data);
        @(posedge i_Clk);
        i_SlaveSel     <= 1'b1;
        i_AV_Write     <= 1'b1;
        i_RegAddr      <= 30'(addr);
        i_AV_ByteEn    <= byteen;
        i_AV_WriteData <= data;
        @(posedge i_Clk);
        i_SlaveSel <= 1'b0;
        i_AV_Write <= 1'b0;
    endtask

    task automatic bus_read(input int addr, output bus_word_t data);
        @(posedge i_Clk);
        i_SlaveSel <= 1'b1;
        i_AV_Read  <= 1'b1;
        i_RegAddr  <= 30'(addr);
        @(posedge i_Clk);
        i_SlaveSel <= 1'b0;
        i_AV_Read  <= 1'b0;
        // Registered response holds until the next rising edge
        @(negedge i_Clk);
        data = o_AV_ReadData;
    endtask

    task automatic read_expect(input int addr, input string name, input bus_word_t exp);
        bus_word_t rd;
        bus_read(addr, rd);
        check_word(name, rd, exp);
    endtask

    function automatic sample_t merge_bytes(input sample_t old, input logic [3:0] be,
                                            input bus_word_t data);
        sample_t mask;
        mask = {{8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old & ~mask) | (data[SAMPLE_W-1:0] & mask);
    endfunction

    task automatic stage_sample(input int addr, input logic [3:0] be, inout sample_t model);
        bus_word_t data;
        data = $urandom;
        bus_write(addr, be, data);
        model = merge_bytes(model, be, data);
        read_expect(addr, (addr == REG_ADDR_DATAL) ? "DATAL" : "DATAR", bus_word_t'(model));
    endtask

    function automatic frame_t random_frame();
        frame_t f;
        f = {sample_t'($urandom), sample_t'($urandom)};
        // All zeros would look like silence at the receiver
        if (f == '0) begin
            f = frame_t'(1);
        end
        return f;
    endfunction

    task automatic send_frame(input frame_t f);
        bus_write(REG_ADDR_DATAL, 4'b0111, bus_word_t'(f[SAMPLE_W-1:0]));
        bus_write(REG_ADDR_DATAR, 4'b0111, bus_word_t'(f[FRAME_W-1:SAMPLE_W]));
        sent_q.push_back(f);
    endtask

    function automatic int count_data();
        int n;
        n = 0;
        foreach (rx_q[i]) begin
            if (rx_q[i] != '0) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic wait_rx(input int n, input bit data_only, input int max_frames);
        int cycles;
        cycles = 0;
        while (((data_only ? count_data() : rx_q.size()) < n)
               && (cycles < max_frames * FRAME_CLKS)) begin
            @(posedge i_Audio_Clk);
            cycles++;
        end
        if ((data_only ? count_data() : rx_q.size()) < n) begin
            $display("Receiver timed out at %0t ns waiting for %0d frames", $time, n);
            errors++;
        end
    endtask

    // Non-silent frames must match the write list in order
    task automatic check_playback();
        int k;
        k = 0;
        foreach (rx_q[i]) begin
            if (rx_q[i] != '0) begin
                if (k < sent_q.size()) begin
                    check_frame("received frame", rx_q[i], sent_q[k]);
                end
                k++;
            end
        end
        if (k != sent_q.size()) begin
            $display("Receiver got %0d data frames at %0t ns, %0d were expected",
                     k, $time, sent_q.size());
            errors++;
        end
    endtask

    initial begin
        bus_word_t rd;
        sample_t   model;
        int        polls;

        void'($urandom(32'hf9a0_52e5));
        i_rst_n        = 1'b0;
        i_SlaveSel     = 1'b0;
        i_RegAddr      = '0;
        i_AV_ByteEn    = '0;
        i_AV_Read      = 1'b0;
        i_AV_Write     = 1'b0;
        i_AV_WriteData = '0;

        repeat (5) @(posedge i_Audio_Clk);
        @(negedge i_Audio_Clk);
        check_bit("o_I2S0_SCLK", o_I2S0_SCLK, 1'b0);
        check_bit("o_I2S0_LRCK", o_I2S0_LRCK, 1'b0);
        check_bit("o_I2S0_SDIN", o_I2S0_SDIN, 1'b0);
        check_bit("o_I2S0_MCLK", o_I2S0_MCLK, 1'b0);
        check_word("o_AV_ReadData", o_AV_ReadData, '0);
        @(posedge i_Clk);
        i_rst_n <= 1'b1;
        // Serializer still in reset sync right after release
        @(negedge i_Audio_Clk);
        check_bit("o_I2S0_SCLK", o_I2S0_SCLK, 1'b0);
        check_bit("o_I2S0_LRCK", o_I2S0_LRCK, 1'b0);
        repeat (4) @(posedge i_Clk);
        read_expect(REG_ADDR_CNTRL, "CNTRL", '0);
        read_expect(REG_ADDR_DATAL, "DATAL", '0);
        read_expect(REG_ADDR_DATAR, "DATAR", '0);
        read_expect(3, "unmapped register", '0);
        end_test("reset state");

        check_mclk();
        end_test("MCLK divider");

        model = '0;
        stage_sample(REG_ADDR_DATAL, 4'b0101, model);
        stage_sample(REG_ADDR_DATAL, 4'b1010, model);
        stage_sample(REG_ADDR_DATAL, 4'b0010, model);
        stage_sample(REG_ADDR_DATAL, 4'b1111, model);
        model = '0;
        stage_sample(REG_ADDR_DATAR, 4'b0011, model);
        stage_sample(REG_ADDR_DATAR, 4'b1001, model);
        // No byte 2 write on DATAR, so nothing is queued
        rx_q.delete();
        wait_rx(3, 1'b0, 4);
        foreach (rx_q[i]) begin
            check_frame("received frame", rx_q[i], '0);
        end
        end_test("byte enables");

        rx_q.delete();
        sent_q.delete();
        for (int i = 0; i < 8; i++) begin
            polls = 0;
            do begin
                bus_read(REG_ADDR_CNTRL, rd);
                polls++;
            end while (rd[0] && polls < 1000);
            if (rd[0]) begin
                $display("Status bit stuck at full at %0t ns", $time);
                errors++;
            end
            send_frame(random_frame());
        end
        wait_rx(8, 1'b1, 12);
        check_playback();
        end_test("playback order");

        rx_q.delete();
        wait_rx(3, 1'b0, 4);
        foreach (rx_q[i]) begin
            check_frame("underrun frame", rx_q[i], '0);
        end
        rx_q.delete();
        sent_q.delete();
        send_frame(random_frame());
        wait_rx(1, 1'b1, 3);
        check_playback();
        end_test("underrun silence");

        // Start just after a request so no pop falls inside the burst
        @(posedge o_I2S0_LRCK);
        repeat (10) @(posedge i_Audio_Clk);
        rx_q.delete();
        sent_q.delete();
        for (int i = 0; i < 20; i++) begin
            send_frame(random_frame());
            if (i == FIFO_DEPTH - 1) begin
                read_expect(REG_ADDR_CNTRL, "CNTRL full", 32'd1);
            end
        end
        read_expect(REG_ADDR_CNTRL, "CNTRL full", 32'd1);
        while (sent_q.size() > FIFO_DEPTH) begin
            void'(sent_q.pop_back());
        end
        wait_rx(FIFO_DEPTH, 1'b1, FIFO_DEPTH + 4);
        repeat (2 * FRAME_CLKS) @(posedge i_Audio_Clk);
        check_playback();
        end_test("full status");

        $display("%0d checks done, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/i2s_pkg.sv
hdl/i2s_bus_regs.sv
hdl/i2s_sample_fifo.sv
hdl/i2s_frame_feeder.sv
hdl/i2s_serializer.sv
hdl/i2s_bus_interface.sv
sim/tb_i2s_bus_interface.sv
